// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_intc
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: intc_checker.sv
`timescale 1ns/1ps

`include "intc_config.svh"

module intc_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  intc_pkg::src_vec_t  set_i,
    input  intc_pkg::src_vec_t  en_i,
    input  logic                iret_i,
    input  intc_pkg::vec_id_t   vector_i,
    input  intc_pkg::upper_en_t upper_en_i,
    input  int                  test_id_i,
    output int                  tests_run_o,
    output int                  tests_failed_o,
    output int                  errors_o
);

    import intc_pkg::*;

    // reference state, as held by the DUT after the last rising edge
    src_vec_t m_isr;
    vec_id_t  m_vec;

    int cur_test;
    int test_checks;
    int test_errors;
    int total_checks;

    initial begin
        m_isr          = '0;
        m_vec          = vec_id_t'(`INTC_IDLE_VEC);
        cur_test       = 0;
        test_checks    = 0;
        test_errors    = 0;
        total_checks   = 0;
        tests_run_o    = 0;
        tests_failed_o = 0;
        errors_o       = 0;
    end

    // lowest index that is requesting or in service, source count when none
    function automatic int first_busy(input src_vec_t req, input src_vec_t isr);
        for (int i = 0; i < `INTC_NUM_SRC; i++) begin
            if (req[i] || isr[i]) begin
                return i;
            end
        end
        return `INTC_NUM_SRC;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset";
            2: return "single request";
            3: return "priority and blocking";
            4: return "preemption";
            5: return "iret";
            6: return "random";
            default: return "unknown";
        endcase
    endfunction

    task automatic close_test();
        tests_run_o++;
        if (test_errors != 0) begin
            tests_failed_o++;
        end
        $display("test %0d (%s): %s, %0d checks, %0d errors", cur_test,
                 test_name(cur_test), (test_errors == 0) ? "ok" : "bad",
                 test_checks, test_errors);
    endtask

    // inputs and DUT outputs are both settled at the falling edge
    always @(negedge clk) begin : compare
        int        busy;
        int        lowest;
        int        idx;
        upper_en_t exp_upper;

        if (test_id_i != cur_test) begin
            if (cur_test != 0) begin
                close_test();
            end
            cur_test    = test_id_i;
            test_checks = 0;
            test_errors = 0;
            if (cur_test == 0) begin
                $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                         tests_run_o, tests_failed_o, total_checks, errors_o);
            end
        end

        if (!rst_n) begin
            m_isr = '0;
            m_vec = vec_id_t'(`INTC_IDLE_VEC);
        end

        if (cur_test != 0) begin
            busy   = first_busy(set_i, m_isr);
            lowest = first_busy('0, m_isr);
            // upper source may interrupt if nothing below is busy and it is idle itself
            for (int k = 0; k < `INTC_UPPER_W; k++) begin
                idx          = `INTC_UPPER_BASE + k;
                exp_upper[k] = (busy >= idx) && !m_isr[idx];
            end

            test_checks  += 2;
            total_checks += 2;
            if (vector_i !== m_vec) begin
                test_errors++;
                errors_o++;
                $display("FAIL @ %0t: %s, vector_o = %0d, expected %0d",
                         $time, test_name(cur_test), vector_i, m_vec);
            end
            if (upper_en_i !== exp_upper) begin
                test_errors++;
                errors_o++;
                $display("FAIL @ %0t: %s, upper_en_o = %h, expected %h",
                         $time, test_name(cur_test), upper_en_i, exp_upper);
            end

            // next edge: vector takes the current lowest, then admit, then clear wins
            if (rst_n) begin
                m_vec = (lowest < `INTC_NUM_SRC) ? vec_id_t'(lowest)
                                                 : vec_id_t'(`INTC_IDLE_VEC);
                if (busy < `INTC_NUM_SRC && set_i[busy] && en_i[busy]) begin
                    m_isr[busy] = 1'b1;
                end
                if (iret_i && lowest < `INTC_NUM_SRC) begin
                    m_isr[lowest] = 1'b0;
                end
            end
        end
    end

endmodule

// File: intc_config.svh
`ifndef INTC_CONFIG_SVH
`define INTC_CONFIG_SVH

// number of interrupt sources, index 0 is the most urgent
`define INTC_NUM_SRC 63

// vector index width, wide enough for the idle code
`define INTC_VEC_W 6

// vector value when no handler is active
`define INTC_IDLE_VEC 63

// upper sources that get a live may-interrupt flag
`define INTC_UPPER_BASE 32
`define INTC_UPPER_W 31

`endif

// File: intc_pkg.sv
package intc_pkg;

    `include "intc_config.svh"

    // one bit per source
    // used for requests, enables, in-service state and masks
    typedef logic [`INTC_NUM_SRC-1:0] src_vec_t;

    // index of an interrupt source, or the idle code
    typedef logic [`INTC_VEC_W-1:0] vec_id_t;

    // may-interrupt flags for sources 32 and up
    typedef logic [`INTC_UPPER_W-1:0] upper_en_t;

endpackage

// File: intc_priority_resolve.sv
`timescale 1ns/1ps

`include "intc_config.svh"

module intc_priority_resolve (
    input  intc_pkg::src_vec_t  set_i,
    input  intc_pkg::src_vec_t  en_i,
    input  intc_pkg::src_vec_t  in_service_i,
    input  logic                iret_i,
    output intc_pkg::src_vec_t  admit_o,
    output intc_pkg::src_vec_t  clear_o,
    output intc_pkg::upper_en_t upper_en_o
);

    import intc_pkg::*;

    // bit i: something below i is requesting or in service
    src_vec_t req_below;
    // bit i: something below i is in service
    src_vec_t isr_below;
    src_vec_t admit;
    src_vec_t lowest_isr;

    // prefix-OR chains, walked from index 0 upward
    always_comb begin
        logic acc_req;
        logic acc_isr;

        acc_req = 1'b0;
        acc_isr = 1'b0;
        for (int i = 0; i < `INTC_NUM_SRC; i++) begin
            req_below[i] = acc_req;
            isr_below[i] = acc_isr;
            acc_req      = acc_req | set_i[i] | in_service_i[i];
            acc_isr      = acc_isr | in_service_i[i];
        end
    end

    // a lower request blocks even if its own enable is low
    assign admit = set_i & en_i & ~req_below;

    // first in-service bit from the bottom is the running handler
    assign lowest_isr = in_service_i & ~isr_below;

    assign admit_o = admit;
    assign clear_o = iret_i ? lowest_isr : '0;

    // upper sources may interrupt when nothing at or below them is busy
    always_comb begin
        for (int k = 0; k < `INTC_UPPER_W; k++) begin
            upper_en_o[k] = ~(req_below[`INTC_UPPER_BASE+k]
                              | in_service_i[`INTC_UPPER_BASE+k]);
        end
    end

endmodule

// File: intc_service_bits.sv
`timescale 1ns/1ps

`include "intc_config.svh"

module intc_service_bits (
    input  logic               clk,
    input  logic               rst_n,
    input  intc_pkg::src_vec_t admit_i,
    input  intc_pkg::src_vec_t clear_i,
    output intc_pkg::src_vec_t in_service_o
);

    import intc_pkg::*;

    src_vec_t in_service_q;

    // one flop per source
    // iret clear has priority over a new admission
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_service_q <= '0;
        end else begin
            for (int i = 0; i < `INTC_NUM_SRC; i++) begin
                if (clear_i[i]) begin
                    in_service_q[i] <= 1'b0;
                end else if (admit_i[i]) begin
                    in_service_q[i] <= 1'b1;
                end
            end
        end
    end

    assign in_service_o = in_service_q;

    // iret only ever retires one handler
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(clear_i))
        else $error("clear mask has more than one bit set: %h", clear_i);

    // a handler only starts when it was admitted on the edge before,
    // and nothing more urgent was running at that time
    for (genvar g = 0; g < `INTC_NUM_SRC; g++) begin : g_bit_chk
        localparam src_vec_t LOWER_MASK = (src_vec_t'(1) << g) - src_vec_t'(1);

        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(in_service_q[g]) |->
                $past(admit_i[g]) && (($past(in_service_q) & LOWER_MASK) == '0))
            else $error("source %0d entered service without admission", g);
    end

endmodule

// File: intc_top.sv
`timescale 1ns/1ps

module intc_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                iret_i,
    input  intc_pkg::src_vec_t  set_i,
    input  intc_pkg::src_vec_t  en_i,
    output intc_pkg::vec_id_t   vector_o,
    output intc_pkg::upper_en_t upper_en_o
);

    import intc_pkg::*;

    // resolver to service bits
    src_vec_t admit;
    src_vec_t clear;

    // service bits back to resolver and vector register
    src_vec_t in_service;

    // admission, iret target and upper-source flags
    intc_priority_resolve intc_priority_resolve_inst (
        .set_i        (set_i),
        .en_i         (en_i),
        .in_service_i (in_service),
        .iret_i       (iret_i),
        .admit_o      (admit),
        .clear_o      (clear),
        .upper_en_o   (upper_en_o)
    );

    // nested handler state, one bit per source
    intc_service_bits intc_service_bits_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .admit_i      (admit),
        .clear_i      (clear),
        .in_service_o (in_service)
    );

    // active vector, one edge behind the service bits
    intc_vector_reg intc_vector_reg_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_service_i (in_service),
        .vector_o     (vector_o)
    );

endmodule

// File: intc_vector_reg.sv
`timescale 1ns/1ps

`include "intc_config.svh"

module intc_vector_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  intc_pkg::src_vec_t in_service_i,
    output intc_pkg::vec_id_t  vector_o
);

    import intc_pkg::*;

    vec_id_t lowest_idx;
    vec_id_t vector_q;

    // priority encoder, lowest in-service index wins
    // scanning downward lets the last hit be the lowest
    always_comb begin
        lowest_idx = vec_id_t'(`INTC_IDLE_VEC);
        for (int i = `INTC_NUM_SRC - 1; i >= 0; i--) begin
            if (in_service_i[i]) begin
                lowest_idx = vec_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vector_q <= vec_id_t'(`INTC_IDLE_VEC);
        end else begin
            vector_q <= lowest_idx;
        end
    end

    assign vector_o = vector_q;

endmodule

// File: tb.f
+incdir+.
intc_pkg.sv
intc_priority_resolve.sv
intc_service_bits.sv
intc_vector_reg.sv
intc_top.sv
intc_checker.sv
tb_intc.sv

// File: tb_intc.sv
`timescale 1ns/1ps

`include "intc_config.svh"

module tb_intc;

    import intc_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 150;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MARGIN_CYCLES   = 100;

    logic      clk;
    logic      rst_n;
    logic      iret_i;
    src_vec_t  set_i;
    src_vec_t  en_i;
    vec_id_t   vector_o;
    upper_en_t upper_en_o;

    int          test_id;
    int          tests_run;
    int          tests_failed;
    int          errors;
    logic [31:0] rng_state;

    intc_top intc_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .iret_i     (iret_i),
        .set_i      (set_i),
        .en_i       (en_i),
        .vector_o   (vector_o),
        .upper_en_o (upper_en_o)
    );

    intc_checker intc_checker_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .set_i          (set_i),
        .en_i           (en_i),
        .iret_i         (iret_i),
        .vector_i       (vector_o),
        .upper_en_i     (upper_en_o),
        .test_id_i      (test_id),
        .tests_run_o    (tests_run),
        .tests_failed_o (tests_failed),
        .errors_o       (errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form, x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        logic b;
        b         = rng_state[0];
        rng_state = lfsr_next(rng_state);
        return b;
    endfunction

    function automatic src_vec_t bit_at(input int n);
        return src_vec_t'(1) << n;
    endfunction

    task automatic apply_inputs(input src_vec_t set, input src_vec_t en, input logic iret);
        @(posedge clk);
        #DRIVE_DELAY;
        set_i  = set;
        en_i   = en;
        iret_i = iret;
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) apply_inputs('0, '1, 1'b0);
    endtask

    task automatic iret_pulse();
        apply_inputs('0, '1, 1'b1);
        apply_inputs('0, '1, 1'b0);
    endtask

    // leaves nothing in service, extra pulses hit an idle controller
    task automatic retire_all();
        repeat (4) iret_pulse();
        quiet_cycles(2);
    endtask

    task automatic random_cycle();
        src_vec_t set;
        src_vec_t en;
        logic     a;
        logic     b;
        logic     c;
        for (int i = 0; i < `INTC_NUM_SRC; i++) begin
            a      = take_bit();
            b      = take_bit();
            c      = take_bit();
            set[i] = a & b & c;
            a      = take_bit();
            b      = take_bit();
            en[i]  = a | b;
        end
        a = take_bit();
        b = take_bit();
        apply_inputs(set, en, a & b);
    endtask

    initial begin : stimulus
        rng_state = 32'hfb03_96bf;
        rst_n     = 1'b0;
        set_i     = '0;
        en_i      = '1;
        iret_i    = 1'b0;
        test_id   = 1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        quiet_cycles(4);

        test_id = 2;
        apply_inputs(bit_at(5), '1, 1'b0);
        quiet_cycles(3);
        iret_pulse();
        quiet_cycles(2);
        apply_inputs(bit_at(50), '1, 1'b0);
        quiet_cycles(3);
        retire_all();
        // masked source never gets in
        repeat (4) apply_inputs(bit_at(40), ~bit_at(40), 1'b0);
        quiet_cycles(2);

        test_id = 3;
        apply_inputs(bit_at(10) | bit_at(20), '1, 1'b0);
        repeat (3) apply_inputs(bit_at(20), '1, 1'b0);
        apply_inputs(bit_at(20), '1, 1'b1);
        repeat (2) apply_inputs(bit_at(20), '1, 1'b0);
        quiet_cycles(2);
        retire_all();
        repeat (4) apply_inputs(bit_at(3) | bit_at(7), ~bit_at(3), 1'b0);
        quiet_cycles(2);
        apply_inputs(bit_at(12), '1, 1'b0);
        quiet_cycles(2);
        repeat (3) apply_inputs(bit_at(30), '1, 1'b0);
        retire_all();

        test_id = 4;
        apply_inputs(bit_at(40), '1, 1'b0);
        quiet_cycles(2);
        repeat (2) apply_inputs(bit_at(8), '1, 1'b0);
        quiet_cycles(3);
        retire_all();

        // three nested handlers, unwound one at a time
        test_id = 5;
        apply_inputs(bit_at(33), '1, 1'b0);
        quiet_cycles(1);
        apply_inputs(bit_at(9), '1, 1'b0);
        quiet_cycles(1);
        apply_inputs(bit_at(2), '1, 1'b0);
        quiet_cycles(2);
        repeat (4) begin
            iret_pulse();
            quiet_cycles(2);
        end

        test_id = 6;
        repeat (RANDOM_CYCLES) random_cycle();

        test_id = 0;
        quiet_cycles(2);
        if (errors == 0 && tests_failed == 0 && tests_run == 6) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the stimulus did not finish in the expected number of cycles");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
